//--- include/fpu_seq_cfg.svh
`ifndef FPU_SEQ_CFG_SVH
`define FPU_SEQ_CFG_SVH

// ring buffer entries, power of two
`define FPU_SEQ_DEPTH 16
// loop descriptors in flight
`define FPU_SEQ_DESC_DEPTH 4
// width of the repeat counter
`define FPU_SEQ_RPT_BITS 16

// major opcodes seen by the classifier
`define FPU_SEQ_FREP_OPC   7'b0001011
`define FPU_SEQ_OPFP_OPC   7'b1010011
`define FPU_SEQ_SYSTEM_OPC 7'b1110011

// funct7[6:2] of OP-FP instructions that talk to the int side
`define FPU_SEQ_SYNC_F5_CMP   5'b10100
`define FPU_SEQ_SYNC_F5_MV_X  5'b11100
`define FPU_SEQ_SYNC_F5_CVT_X 5'b11000
`define FPU_SEQ_SYNC_F5_MV_F  5'b11110
`define FPU_SEQ_SYNC_F5_CVT_F 5'b11010

`endif

//--- source/fpu_seq_pkg.sv
`default_nettype none

`include "fpu_seq_cfg.svh"

package fpu_seq_pkg;

  // index bits of the ring buffer
  localparam int unsigned RB_IDX_BITS = $clog2(`FPU_SEQ_DEPTH);

  typedef logic [31:0] insn_t;
  typedef logic [63:0] operand_t;
  typedef logic [31:0] qaddr_t;
  typedef logic [4:0]  qid_t;

  // extra msb tells a full buffer from an empty one
  typedef logic [RB_IDX_BITS:0]   rb_ptr_t;
  typedef logic [RB_IDX_BITS-1:0] inst_cnt_t;

  typedef logic [`FPU_SEQ_RPT_BITS-1:0] rpt_cnt_t;

  typedef logic [2:0] stagger_cnt_t;
  // bit 0 rd, bit 1 rs1, bit 2 rs2, bit 3 rs3
  typedef logic [3:0] stagger_mask_t;

endpackage

`default_nettype wire

//--- source/fpu_seq_if.sv
`timescale 1ns/1ps
`default_nettype none

// instruction stream from the classifier into replay
interface fpu_insn_if import fpu_seq_pkg::*; ();
  insn_t    op;
  operand_t argc;
  logic     valid;
  logic     ready;

  modport src (output op, output argc, output valid, input ready);
  modport dst (input op, input argc, input valid, output ready);
endinterface

// loop descriptors from the classifier, through the queue, to replay
interface fpu_desc_if import fpu_seq_pkg::*; ();
  logic          push;
  logic          is_outer;
  inst_cnt_t     max_inst;
  rpt_cnt_t      max_rpt;
  stagger_cnt_t  stagger_max;
  stagger_mask_t stagger_mask;
  logic          full;

  // head of the queue
  logic          valid;
  logic          head_is_outer;
  inst_cnt_t     head_max_inst;
  rpt_cnt_t      head_max_rpt;
  stagger_cnt_t  head_stagger_max;
  stagger_mask_t head_stagger_mask;
  rb_ptr_t       base_ptr;
  logic          pop;
  // current ring buffer write pointer, latched on push
  rb_ptr_t       wr_ptr;

  modport producer (
    output push, is_outer, max_inst, max_rpt, stagger_max, stagger_mask,
    input  full
  );
  modport queue (
    input  push, is_outer, max_inst, max_rpt, stagger_max, stagger_mask, pop, wr_ptr,
    output full, valid, head_is_outer, head_max_inst, head_max_rpt,
    output head_stagger_max, head_stagger_mask, base_ptr
  );
  modport consumer (
    input  valid, head_is_outer, head_max_inst, head_max_rpt, head_stagger_max,
    input  head_stagger_mask, base_ptr,
    output pop, wr_ptr
  );
endinterface

`default_nettype wire

//--- source/fpu_insn_classifier.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_seq_cfg.svh"

module fpu_insn_classifier import fpu_seq_pkg::*; (
  input  insn_t               inp_qdata_op_i,
  input  operand_t            inp_qdata_arga_i,
  input  operand_t            inp_qdata_argc_i,
  input  logic                inp_qvalid_i,
  output logic                inp_qready_o,
  fpu_insn_if.src             rb_o,
  fpu_insn_if.src             direct_o,
  fpu_desc_if.producer        desc_o
);

  logic [6:0] opcode;
  logic [4:0] funct5;
  logic       is_frep;
  logic       is_sync;

  assign opcode = inp_qdata_op_i[6:0];
  assign funct5 = inp_qdata_op_i[31:27];

  assign is_frep = opcode == `FPU_SEQ_FREP_OPC;
  // compares, class, moves and int conversions, plus any CSR access
  assign is_sync = (opcode == `FPU_SEQ_SYSTEM_OPC) ||
                   ((opcode == `FPU_SEQ_OPFP_OPC) &&
                    (funct5 inside {`FPU_SEQ_SYNC_F5_CMP, `FPU_SEQ_SYNC_F5_MV_X,
                                    `FPU_SEQ_SYNC_F5_CVT_X, `FPU_SEQ_SYNC_F5_MV_F,
                                    `FPU_SEQ_SYNC_F5_CVT_F}));

  // payload goes to both streams while only one valid is raised
  assign rb_o.op       = inp_qdata_op_i;
  assign rb_o.argc     = inp_qdata_argc_i;
  assign direct_o.op   = inp_qdata_op_i;
  assign direct_o.argc = inp_qdata_argc_i;

  // frep fields
  assign desc_o.is_outer     = inp_qdata_op_i[7];
  assign desc_o.stagger_mask = inp_qdata_op_i[11:8];
  assign desc_o.stagger_max  = inp_qdata_op_i[14:12];
  assign desc_o.max_inst     = inp_qdata_op_i[20 +: RB_IDX_BITS];
  assign desc_o.max_rpt      = inp_qdata_arga_i[$bits(rpt_cnt_t)-1:0];

  always_comb begin
    rb_o.valid     = 1'b0;
    direct_o.valid = 1'b0;
    desc_o.push    = 1'b0;
    if (is_frep) begin
      inp_qready_o = ~desc_o.full;
      desc_o.push  = inp_qvalid_i & ~desc_o.full;
    end else if (is_sync) begin
      inp_qready_o   = direct_o.ready;
      direct_o.valid = inp_qvalid_i;
    end else begin
      inp_qready_o = rb_o.ready;
      rb_o.valid   = inp_qvalid_i;
    end
  end

endmodule

`default_nettype wire

//--- source/fpu_seq_desc_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_seq_cfg.svh"

module fpu_seq_desc_queue import fpu_seq_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  fpu_desc_if.queue   desc_i
);

  localparam int unsigned DESC_IDX_BITS = $clog2(`FPU_SEQ_DESC_DEPTH);

  // wrap bit on top of the slot index
  typedef logic [DESC_IDX_BITS:0] desc_ptr_t;

  logic          is_outer_mem     [`FPU_SEQ_DESC_DEPTH];
  inst_cnt_t     max_inst_mem     [`FPU_SEQ_DESC_DEPTH];
  rpt_cnt_t      max_rpt_mem      [`FPU_SEQ_DESC_DEPTH];
  stagger_cnt_t  stagger_max_mem  [`FPU_SEQ_DESC_DEPTH];
  stagger_mask_t stagger_mask_mem [`FPU_SEQ_DESC_DEPTH];
  rb_ptr_t       base_ptr_mem     [`FPU_SEQ_DESC_DEPTH];

  desc_ptr_t wr_q;
  desc_ptr_t rd_q;

  always_ff @(posedge clk_i) begin
    if (desc_i.push) begin
      is_outer_mem[wr_q[DESC_IDX_BITS-1:0]]     <= desc_i.is_outer;
      max_inst_mem[wr_q[DESC_IDX_BITS-1:0]]     <= desc_i.max_inst;
      max_rpt_mem[wr_q[DESC_IDX_BITS-1:0]]      <= desc_i.max_rpt;
      stagger_max_mem[wr_q[DESC_IDX_BITS-1:0]]  <= desc_i.stagger_max;
      stagger_mask_mem[wr_q[DESC_IDX_BITS-1:0]] <= desc_i.stagger_mask;
      // body of this loop starts at the next buffered entry
      base_ptr_mem[wr_q[DESC_IDX_BITS-1:0]]     <= desc_i.wr_ptr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_q <= '0;
      rd_q <= '0;
    end else begin
      if (desc_i.push)
        wr_q <= wr_q + desc_ptr_t'(1);
      if (desc_i.pop)
        rd_q <= rd_q + desc_ptr_t'(1);
    end
  end

  assign desc_i.full  = (wr_q ^ rd_q) == desc_ptr_t'(`FPU_SEQ_DESC_DEPTH);
  assign desc_i.valid = wr_q != rd_q;

  assign desc_i.head_is_outer     = is_outer_mem[rd_q[DESC_IDX_BITS-1:0]];
  assign desc_i.head_max_inst     = max_inst_mem[rd_q[DESC_IDX_BITS-1:0]];
  assign desc_i.head_max_rpt      = max_rpt_mem[rd_q[DESC_IDX_BITS-1:0]];
  assign desc_i.head_stagger_max  = stagger_max_mem[rd_q[DESC_IDX_BITS-1:0]];
  assign desc_i.head_stagger_mask = stagger_mask_mem[rd_q[DESC_IDX_BITS-1:0]];
  assign desc_i.base_ptr          = base_ptr_mem[rd_q[DESC_IDX_BITS-1:0]];

  // classifier gates push on full, replay only pops a matching head
  assert property (@(posedge clk_i) disable iff (rst_i)
    !(desc_i.push && desc_i.full) && !(desc_i.pop && !desc_i.valid))
    else $error("descriptor queue overflow or underflow");

endmodule

`default_nettype wire

//--- source/fpu_seq_replay.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_seq_cfg.svh"

module fpu_seq_replay import fpu_seq_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  fpu_insn_if.dst      rb_i,
  fpu_insn_if.dst      direct_i,
  fpu_desc_if.consumer desc_i,
  input  qaddr_t       direct_qaddr_i,
  input  qid_t         direct_qid_i,
  input  operand_t     direct_arga_i,
  input  operand_t     direct_argb_i,
  output qaddr_t       oup_qaddr_o,
  output qid_t         oup_qid_o,
  output insn_t        oup_qdata_op_o,
  output operand_t     oup_qdata_arga_o,
  output operand_t     oup_qdata_argb_o,
  output operand_t     oup_qdata_argc_o,
  output logic         oup_qvalid_o,
  input  logic         oup_qready_i
);

  // ring buffer, argc is kept at 32 bits
  insn_t       mem_op   [`FPU_SEQ_DEPTH];
  logic [31:0] mem_argc [`FPU_SEQ_DEPTH];

  rb_ptr_t      wr_ptr_q;
  rb_ptr_t      rd_base_q;
  rb_ptr_t      rd_ptr;
  inst_cnt_t    inst_cnt_q;
  rpt_cnt_t     rpt_cnt_q;
  stagger_cnt_t stagger_cnt_q;
  stagger_cnt_t stagger_nxt;

  logic        rb_wr;
  logic        rb_has_body;
  insn_t       rd_op;
  logic [31:0] rd_argc;
  insn_t       seq_op;

  // loop config of the body at the read base
  logic          cfg_hit;
  logic          cur_is_outer;
  inst_cnt_t     cur_max_inst;
  rpt_cnt_t      cur_max_rpt;
  stagger_cnt_t  cur_stagger_max;
  stagger_mask_t cur_stagger_mask;

  logic inst_last;
  logic rpt_last;
  logic seq_last;
  logic seq_valid;
  logic seq_ready;
  logic seq_next;

  assign rb_wr       = rb_i.valid & rb_i.ready;
  assign rb_i.ready  = (wr_ptr_q ^ rd_base_q) != rb_ptr_t'(`FPU_SEQ_DEPTH);
  assign rb_has_body = wr_ptr_q != rd_base_q;
  assign rd_ptr      = rd_base_q + rb_ptr_t'(inst_cnt_q);
  assign seq_valid   = rd_ptr != wr_ptr_q;

  always_ff @(posedge clk_i) begin
    if (rb_wr) begin
      mem_op[wr_ptr_q[RB_IDX_BITS-1:0]]   <= rb_i.op;
      mem_argc[wr_ptr_q[RB_IDX_BITS-1:0]] <= rb_i.argc[31:0];
    end
  end

  assign rd_op   = mem_op[rd_ptr[RB_IDX_BITS-1:0]];
  assign rd_argc = mem_argc[rd_ptr[RB_IDX_BITS-1:0]];

  // a body without a descriptor of its own issues once
  assign cfg_hit          = desc_i.valid && (desc_i.base_ptr == rd_base_q);
  assign cur_is_outer     = cfg_hit & desc_i.head_is_outer;
  assign cur_max_inst     = cfg_hit ? desc_i.head_max_inst : '0;
  assign cur_max_rpt      = cfg_hit ? desc_i.head_max_rpt : '0;
  assign cur_stagger_max  = cfg_hit ? desc_i.head_stagger_max : '0;
  assign cur_stagger_mask = cfg_hit ? desc_i.head_stagger_mask : '0;

  assign inst_last   = inst_cnt_q == cur_max_inst;
  assign rpt_last    = rpt_cnt_q == cur_max_rpt;
  assign seq_last    = inst_last & rpt_last;
  assign seq_next    = seq_valid & seq_ready;
  assign stagger_nxt = (stagger_cnt_q == cur_stagger_max) ? '0 : stagger_cnt_q + stagger_cnt_t'(1);

  assign desc_i.pop    = seq_last & seq_next & cfg_hit;
  assign desc_i.wr_ptr = wr_ptr_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q      <= '0;
      rd_base_q     <= '0;
      inst_cnt_q    <= '0;
      rpt_cnt_q     <= '0;
      stagger_cnt_q <= '0;
    end else begin
      if (rb_wr)
        wr_ptr_q <= wr_ptr_q + rb_ptr_t'(1);
      if (seq_next && seq_last)
        rd_base_q <= rd_base_q + rb_ptr_t'(cur_max_inst) + rb_ptr_t'(1);
      if (seq_next) begin
        if (cur_is_outer) begin
          // outer loop, walk the body then restart it
          if (inst_last) begin
            inst_cnt_q    <= '0;
            rpt_cnt_q     <= rpt_last ? '0 : rpt_cnt_q + rpt_cnt_t'(1);
            stagger_cnt_q <= rpt_last ? '0 : stagger_nxt;
          end else begin
            inst_cnt_q <= inst_cnt_q + inst_cnt_t'(1);
          end
        end else if (rpt_last) begin
          rpt_cnt_q     <= '0;
          inst_cnt_q    <= inst_last ? '0 : inst_cnt_q + inst_cnt_t'(1);
          stagger_cnt_q <= inst_last ? '0 : stagger_nxt;
        end else begin
          rpt_cnt_q     <= rpt_cnt_q + rpt_cnt_t'(1);
          stagger_cnt_q <= stagger_nxt;
        end
      end
    end
  end

  // register field stagger, wraps modulo 32
  always_comb begin
    seq_op = rd_op;
    if (cur_stagger_mask[0])
      seq_op[11:7] = rd_op[11:7] + qid_t'(stagger_cnt_q);
    if (cur_stagger_mask[1])
      seq_op[19:15] = rd_op[19:15] + qid_t'(stagger_cnt_q);
    if (cur_stagger_mask[2])
      seq_op[24:20] = rd_op[24:20] + qid_t'(stagger_cnt_q);
    if (cur_stagger_mask[3])
      seq_op[31:27] = rd_op[31:27] + qid_t'(stagger_cnt_q);
  end

  // direct path only wins once no body is left in the buffer
  always_comb begin
    oup_qvalid_o     = direct_i.valid;
    oup_qaddr_o      = direct_qaddr_i;
    oup_qid_o        = direct_qid_i;
    oup_qdata_op_o   = direct_i.op;
    oup_qdata_arga_o = direct_arga_i;
    oup_qdata_argb_o = direct_argb_i;
    oup_qdata_argc_o = direct_i.argc;
    direct_i.ready   = 1'b0;
    seq_ready        = 1'b0;
    if (rb_has_body) begin
      oup_qvalid_o     = seq_valid;
      oup_qaddr_o      = '0;
      oup_qid_o        = '0;
      oup_qdata_op_o   = seq_op;
      oup_qdata_arga_o = '0;
      oup_qdata_argb_o = '0;
      oup_qdata_argc_o = {{32{rd_argc[31]}}, rd_argc};
      seq_ready        = oup_qready_i;
    end else begin
      direct_i.ready = oup_qready_i;
    end
  end

  // reads stay inside the written part of the current body
  assert property (@(posedge clk_i) disable iff (rst_i)
    rb_ptr_t'(wr_ptr_q - rd_base_q) >= rb_ptr_t'(inst_cnt_q))
    else $error("replay read pointer ran past the write pointer");

  assert property (@(posedge clk_i) disable iff (rst_i)
    rb_ptr_t'(wr_ptr_q - rd_base_q) <= rb_ptr_t'(`FPU_SEQ_DEPTH))
    else $error("ring buffer write pointer ran ahead of the read base");

endmodule

`default_nettype wire

//--- source/fpu_seq_top.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_seq_top import fpu_seq_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  qaddr_t   inp_qaddr_i,
  input  qid_t     inp_qid_i,
  input  insn_t    inp_qdata_op_i,
  input  operand_t inp_qdata_arga_i,
  input  operand_t inp_qdata_argb_i,
  input  operand_t inp_qdata_argc_i,
  input  logic     inp_qvalid_i,
  output logic     inp_qready_o,
  output qaddr_t   oup_qaddr_o,
  output qid_t     oup_qid_o,
  output insn_t    oup_qdata_op_o,
  output operand_t oup_qdata_arga_o,
  output operand_t oup_qdata_argb_o,
  output operand_t oup_qdata_argc_o,
  output logic     oup_qvalid_o,
  input  logic     oup_qready_i
);

  fpu_insn_if rb_stream ();
  fpu_insn_if direct_stream ();
  fpu_desc_if desc_link ();

  // sort requests into buffer, bypass and loop descriptor
  fpu_insn_classifier fpu_insn_classifier_inst (
    .inp_qdata_op_i   (inp_qdata_op_i),
    .inp_qdata_arga_i (inp_qdata_arga_i),
    .inp_qdata_argc_i (inp_qdata_argc_i),
    .inp_qvalid_i     (inp_qvalid_i),
    .inp_qready_o     (inp_qready_o),
    .rb_o             (rb_stream),
    .direct_o         (direct_stream),
    .desc_o           (desc_link)
  );

  fpu_seq_desc_queue fpu_seq_desc_queue_inst (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .desc_i (desc_link)
  );

  fpu_seq_replay fpu_seq_replay_inst (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .rb_i             (rb_stream),
    .direct_i         (direct_stream),
    .desc_i           (desc_link),
    .direct_qaddr_i   (inp_qaddr_i),
    .direct_qid_i     (inp_qid_i),
    .direct_arga_i    (inp_qdata_arga_i),
    .direct_argb_i    (inp_qdata_argb_i),
    .oup_qaddr_o      (oup_qaddr_o),
    .oup_qid_o        (oup_qid_o),
    .oup_qdata_op_o   (oup_qdata_op_o),
    .oup_qdata_arga_o (oup_qdata_arga_o),
    .oup_qdata_argb_o (oup_qdata_argb_o),
    .oup_qdata_argc_o (oup_qdata_argc_o),
    .oup_qvalid_o     (oup_qvalid_o),
    .oup_qready_i     (oup_qready_i)
  );

endmodule

`default_nettype wire

//--- bench/tb_fpu_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_seq_cfg.svh"

module tb_fpu_seq import fpu_seq_pkg::*; ();

  typedef struct packed {
    qaddr_t   addr;
    qid_t     id;
    insn_t    op;
    operand_t arga;
    operand_t argb;
    operand_t argc;
  } req_t;

  logic     clk;
  logic     rst;
  req_t     inp;
  logic     inp_qvalid;
  logic     inp_qready;
  qaddr_t   oup_qaddr;
  qid_t     oup_qid;
  insn_t    oup_qdata_op;
  operand_t oup_qdata_arga;
  operand_t oup_qdata_argb;
  operand_t oup_qdata_argc;
  logic     oup_qvalid;
  logic     oup_qready;

  // requests to send and the outputs the model expects, in order
  req_t        req_q [$];
  req_t        exp_q [$];
  logic [31:0] rng_state;
  int          errors;
  int          test_errors;
  logic        timed_out;

  fpu_seq_top fpu_seq_top_inst (
    .clk_i            (clk),
    .rst_i            (rst),
    .inp_qaddr_i      (inp.addr),
    .inp_qid_i        (inp.id),
    .inp_qdata_op_i   (inp.op),
    .inp_qdata_arga_i (inp.arga),
    .inp_qdata_argb_i (inp.argb),
    .inp_qdata_argc_i (inp.argc),
    .inp_qvalid_i     (inp_qvalid),
    .inp_qready_o     (inp_qready),
    .oup_qaddr_o      (oup_qaddr),
    .oup_qid_o        (oup_qid),
    .oup_qdata_op_o   (oup_qdata_op),
    .oup_qdata_arga_o (oup_qdata_arga),
    .oup_qdata_argb_o (oup_qdata_argb),
    .oup_qdata_argc_o (oup_qdata_argc),
    .oup_qvalid_o     (oup_qvalid),
    .oup_qready_i     (oup_qready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic req_t rand_req();
    req_t r;
    r.addr = next_rand();
    r.id   = 5'(next_rand());
    r.op   = next_rand();
    r.arga = {next_rand(), next_rand()};
    r.argb = {next_rand(), next_rand()};
    r.argc = {next_rand(), next_rand()};
    return r;
  endfunction

  // OP-FP funct5 values that go straight to the int side
  function automatic logic is_sync_f5(input logic [4:0] f5);
    return (f5 == `FPU_SEQ_SYNC_F5_CMP) || (f5 == `FPU_SEQ_SYNC_F5_MV_X) ||
           (f5 == `FPU_SEQ_SYNC_F5_CVT_X) || (f5 == `FPU_SEQ_SYNC_F5_MV_F) ||
           (f5 == `FPU_SEQ_SYNC_F5_CVT_F);
  endfunction

  // expected output of one buffered instruction at stagger count s
  function automatic req_t replayed(input req_t b, input logic [3:0] mask, input logic [2:0] s);
    req_t res;
    res      = '0;
    res.op   = b.op;
    res.argc = {{32{b.argc[31]}}, b.argc[31:0]};
    if (mask[0])
      res.op[11:7] = b.op[11:7] + 5'(s);
    if (mask[1])
      res.op[19:15] = b.op[19:15] + 5'(s);
    if (mask[2])
      res.op[24:20] = b.op[24:20] + 5'(s);
    if (mask[3])
      res.op[31:27] = b.op[31:27] + 5'(s);
    return res;
  endfunction

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, want);
      test_errors++;
    end
  endtask

  // sync request that passes through unchanged
  task automatic add_direct();
    req_t d;
    d = rand_req();
    if (next_rand() % 4 == 0) begin
      d.op[6:0] = `FPU_SEQ_SYSTEM_OPC;
    end else begin
      d.op[6:0] = `FPU_SEQ_OPFP_OPC;
      case (next_rand() % 5)
        0: d.op[31:27] = `FPU_SEQ_SYNC_F5_CMP;
        1: d.op[31:27] = `FPU_SEQ_SYNC_F5_MV_X;
        2: d.op[31:27] = `FPU_SEQ_SYNC_F5_CVT_X;
        3: d.op[31:27] = `FPU_SEQ_SYNC_F5_MV_F;
        default: d.op[31:27] = `FPU_SEQ_SYNC_F5_CVT_F;
      endcase
    end
    req_q.push_back(d);
    exp_q.push_back(d);
  endtask

  // kind 0 plain body, 1 inner, 2 outer, 3 staggered, 4 anything, 5 short loop
  task automatic add_program(input int kind);
    req_t       frep;
    req_t       b;
    req_t       body [$];
    logic       has_frep;
    logic       outer;
    logic [3:0] mask;
    logic [2:0] smax;
    logic [2:0] s;
    int         len;
    int         rpt;
    has_frep = (kind != 0) && !((kind == 4) && (next_rand() % 4 == 0));
    outer    = (kind == 2) || ((kind >= 3) && (next_rand() % 2 == 1));
    mask     = (kind >= 3) ? 4'(next_rand() % 15 + 1) : 4'b0;
    smax     = 3'(next_rand());
    if (kind == 4)
      len = int'(next_rand() % 16) + 1;
    else if (kind == 5)
      len = int'(next_rand() % 2) + 1;
    else
      len = int'(next_rand() % 6) + 1;
    rpt      = int'(next_rand() % 4);
    if (has_frep) begin
      frep              = rand_req();
      frep.op[6:0]      = `FPU_SEQ_FREP_OPC;
      frep.op[7]        = outer;
      frep.op[11:8]     = mask;
      frep.op[14:12]    = smax;
      frep.op[23:20]    = 4'(len - 1);
      frep.arga[15:0]   = 16'(rpt);
      req_q.push_back(frep);
    end else begin
      // without a descriptor every entry issues once
      outer = 1'b0;
      mask  = 4'b0;
      rpt   = 0;
    end
    for (int i = 0; i < len; i++) begin
      b = rand_req();
      b.op[6:0] = `FPU_SEQ_OPFP_OPC;
      if (is_sync_f5(b.op[31:27]))
        b.op[31:27] = 5'b00000;
      body.push_back(b);
      req_q.push_back(b);
    end
    s = 3'd0;
    if (outer) begin
      for (int r = 0; r <= rpt; r++) begin
        for (int i = 0; i < len; i++)
          exp_q.push_back(replayed(body[i], mask, s));
        s = (s == smax) ? 3'd0 : s + 3'd1;
      end
    end else begin
      for (int i = 0; i < len; i++) begin
        for (int r = 0; r <= rpt; r++) begin
          exp_q.push_back(replayed(body[i], mask, s));
          s = (s == smax) ? 3'd0 : s + 3'd1;
        end
      end
    end
    if (kind != 5 && (kind == 0 || next_rand() % 2 == 0))
      add_direct();
  endtask

  task automatic check_idle();
    test_errors = 0;
    repeat (8) begin
      @(negedge clk);
      #2;
      compare("oup_qvalid_o", 64'(oup_qvalid), 64'd0);
    end
    $display("test idle after reset: %0d mismatches", test_errors);
    errors += test_errors;
  endtask

  // sends req_q and checks every output handshake against exp_q
  task automatic run_test(input string name, input int ready_pct);
    req_t want;
    int   idx;
    int   cycles;
    logic presenting;
    test_errors = 0;
    idx         = 0;
    cycles      = 0;
    presenting  = 1'b0;
    while (!timed_out && (idx < req_q.size() || exp_q.size() > 0)) begin
      @(negedge clk);
      if (!presenting && idx < req_q.size() && next_rand() % 4 != 0) begin
        inp        = req_q[idx];
        presenting = 1'b1;
      end
      inp_qvalid = presenting;
      oup_qready = (next_rand() % 100) < ready_pct;
      #2;
      if (oup_qvalid && oup_qready) begin
        if (exp_q.size() == 0) begin
          $display("unexpected output with op 0x%h in test %s", oup_qdata_op, name);
          test_errors++;
        end else begin
          want = exp_q.pop_front();
          compare("oup_qaddr_o", 64'(oup_qaddr), 64'(want.addr));
          compare("oup_qid_o", 64'(oup_qid), 64'(want.id));
          compare("oup_qdata_op_o", 64'(oup_qdata_op), 64'(want.op));
          compare("oup_qdata_arga_o", oup_qdata_arga, want.arga);
          compare("oup_qdata_argb_o", oup_qdata_argb, want.argb);
          compare("oup_qdata_argc_o", oup_qdata_argc, want.argc);
        end
      end
      if (inp_qvalid && inp_qready) begin
        idx++;
        presenting = 1'b0;
      end
      cycles++;
      if (cycles > 50000) begin
        $display("timeout in test %s, %0d requests unsent and %0d outputs missing",
                 name, req_q.size() - idx, exp_q.size());
        timed_out = 1'b1;
        test_errors++;
      end
    end
    // nothing may follow the last expected output
    repeat (4) begin
      @(negedge clk);
      inp_qvalid = 1'b0;
      oup_qready = 1'b1;
      #2;
      if (!timed_out)
        compare("oup_qvalid_o", 64'(oup_qvalid), 64'd0);
    end
    $display("test %s: %0d requests, %0d mismatches", name, idx, test_errors);
    req_q.delete();
    exp_q.delete();
    errors += test_errors;
  endtask

  initial begin
    rng_state  = 32'd37084;
    errors     = 0;
    timed_out  = 1'b0;
    rst        = 1'b1;
    inp        = '0;
    inp_qvalid = 1'b0;
    oup_qready = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_idle();
    add_direct();
    repeat (6) add_program(0);
    run_test("plain body and direct", 75);
    repeat (6) add_program(1);
    run_test("inner frep", 75);
    repeat (6) add_program(2);
    run_test("outer frep", 75);
    repeat (8) add_program(3);
    run_test("stagger", 75);
    // slow consumer so the ring buffer fills up
    repeat (40) add_program(4);
    run_test("random back-pressure", 20);
    // short loops and no bypass so the descriptor queue fills up
    repeat (16) add_program(5);
    run_test("descriptor queue full", 10);
    $display("all tests done, %0d mismatches and timeouts in total", errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
source/fpu_seq_pkg.sv
source/fpu_seq_if.sv
source/fpu_insn_classifier.sv
source/fpu_seq_desc_queue.sv
source/fpu_seq_replay.sv
source/fpu_seq_top.sv
bench/tb_fpu_seq.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then search the log for the pass line
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
  --top-module tb_fpu_seq -o tb_fpu_seq > build.log 2>&1 \
  && ./obj_dir/tb_fpu_seq > sim.log 2>&1 \
  || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "^Finished with no errors$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
